// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := chirp_capture_tb
RTL_TOP    := chirp_capture_top
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/adc_loopback_model.sv ====
`timescale 1ns/1ps

module adc_loopback_model #(
  parameter int adc_delay = 100
) (
  input  logic                      clk_245_76MHz,
  input  logic                      cpu_reset,
  input  chirp_dsp_pkg::iq_sample_t dac_sample_i,
  input  logic                      dac_valid_i,
  output chirp_dsp_pkg::iq_sample_t dac_iq_o,
  output chirp_dsp_pkg::iq_sample_t adc_iq_o,
  output logic                      sample_valid_o
);
  import chirp_dsp_pkg::*;

  iq_sample_t dac_r;
  iq_sample_t dac_rr;
  iq_sample_t adc_delay_q [adc_delay];
  logic       valid_r;
  logic       valid_rr;

  // two register stages of the dac path
  always_ff @(posedge clk_245_76MHz) begin
    dac_r  <= dac_sample_i;
    dac_rr <= dac_r;
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      valid_r  <= 1'b0;
      valid_rr <= 1'b0;
    end else begin
      valid_r  <= dac_valid_i;
      valid_rr <= valid_r;
    end
  end

  // adc sees half amplitude, arithmetic shift floors toward minus infinity
  // delay line stands in for the converter round trip
  always_ff @(posedge clk_245_76MHz) begin
    adc_delay_q[0].i <= {dac_rr.i[sample_w-1], dac_rr.i[sample_w-1:1]};
    adc_delay_q[0].q <= {dac_rr.q[sample_w-1], dac_rr.q[sample_w-1:1]};
    for (int d = 1; d < adc_delay; d++) begin
      adc_delay_q[d] <= adc_delay_q[d-1];
    end
  end

  assign dac_iq_o       = dac_rr;
  assign adc_iq_o       = adc_delay_q[adc_delay-1];
  assign sample_valid_o = valid_rr;

endmodule

// ==== rtl/capture_fifo.sv ====
`timescale 1ns/1ps

module capture_fifo #(
  parameter int fifo_depth = 512
) (
  input  logic                       clk_245_76MHz,
  input  logic                       cpu_reset,
  input  capture_pkg::capture_word_t wr_data_i,
  input  logic                       wr_last_i,
  input  logic                       wr_en_i,
  output capture_pkg::capture_word_t m_tdata_o,
  output logic                       m_tvalid_o,
  output logic                       m_tlast_o,
  input  logic                       m_tready_i,
  output logic                       overflow_o
);
  import capture_pkg::*;

  localparam int addr_w = $clog2(fifo_depth);

  // word plus its frame end flag
  typedef struct packed {
    logic          last;
    capture_word_t word;
  } fifo_entry_t;

  fifo_entry_t       mem [fifo_depth];
  logic [addr_w-1:0] wr_ptr_q;
  logic [addr_w-1:0] rd_ptr_q;
  logic [addr_w:0]   count_q;
  logic              full;
  logic              push;
  logic              pop;
  logic              overflow_q;

  assign full = (count_q == (addr_w + 1)'(fifo_depth));
  // a full fifo drops the incoming word
  assign push = wr_en_i & ~full;
  assign pop  = m_tvalid_o & m_tready_i;

  always_ff @(posedge clk_245_76MHz) begin
    if (push) begin
      mem[wr_ptr_q] <= '{last: wr_last_i, word: wr_data_i};
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      // pointers wrap at depth, any depth allowed
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == addr_w'(fifo_depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == addr_w'(fifo_depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + push - pop;
      // sticky until reset
      if (wr_en_i && full) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // head word shown directly, held until taken
  assign m_tvalid_o = (count_q != '0);
  assign m_tdata_o  = mem[rd_ptr_q].word;
  assign m_tlast_o  = m_tvalid_o & mem[rd_ptr_q].last;
  assign overflow_o = overflow_q;

endmodule

// ==== rtl/capture_framer.sv ====
`timescale 1ns/1ps

module capture_framer #(
  parameter int dds_latency = 2
) (
  input  logic                        clk_245_76MHz,
  input  logic                        cpu_reset,
  input  logic                        adc_enable_i,
  input  chirp_dsp_pkg::iq_sample_t   dac_iq_i,
  input  chirp_dsp_pkg::iq_sample_t   adc_iq_i,
  input  logic                        sample_valid_i,
  chirp_cfg_if.framer                 cfg,
  output capture_pkg::capture_word_t  wr_data_o,
  output logic                        wr_last_o,
  output logic                        wr_en_o
);
  import capture_pkg::*;

  localparam int cnt_w = $clog2(dds_latency + 1);

  logic             enable_r;
  logic             capture_q;
  logic             first_q;
  logic [cnt_w-1:0] latency_cnt_q;
  logic             latency_idle;
  logic [31:0]      adc_cnt_q;
  logic [31:0]      glbl_cnt_q;
  logic             marker;
  logic [31:0]      marker_word;

  // picks one 32 bit capture half
  function automatic logic [31:0] route_mux(input route_sel_e  sel,
                                            input logic [31:0] adc_word,
                                            input logic [31:0] dac_word,
                                            input logic [31:0] adc_cnt,
                                            input logic [31:0] glbl_cnt);
    logic [31:0] word;
    case (sel)
      route_adc_iq:     word = adc_word;
      route_dac_iq:     word = dac_word;
      route_adc_count:  word = adc_cnt;
      default:          word = glbl_cnt;
    endcase
    return word;
  endfunction

  assign latency_idle = (latency_cnt_q == '0);

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      enable_r      <= 1'b0;
      capture_q     <= 1'b0;
      first_q       <= 1'b0;
      latency_cnt_q <= '0;
    end else begin
      enable_r <= adc_enable_i;
      // capture state frozen while the dds tail drains
      if (latency_idle) begin
        capture_q <= enable_r;
      end
      first_q <= latency_idle & enable_r & ~capture_q;
      // falling enable starts the stop countdown
      if (enable_r && !adc_enable_i) begin
        latency_cnt_q <= cnt_w'(dds_latency);
      end else if (!latency_idle) begin
        latency_cnt_q <= latency_cnt_q - 1'b1;
      end
    end
  end

  // closing marker once the countdown has run out
  assign wr_last_o = latency_idle & capture_q & ~enable_r;
  assign marker    = first_q | wr_last_o;
  assign wr_en_o   = capture_q & sample_valid_i;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      adc_cnt_q  <= '0;
      glbl_cnt_q <= '0;
    end else begin
      glbl_cnt_q <= glbl_cnt_q + 1'b1;
      // data words only, markers not counted
      if (wr_en_o && !marker) begin
        adc_cnt_q <= adc_cnt_q + 1'b1;
      end
    end
  end

  assign marker_word = glbl_cnt_q;

  always_comb begin
    if (marker) begin
      wr_data_o.upper = marker_word;
      wr_data_o.lower = adc_cnt_q;
    end else begin
      wr_data_o.upper = route_mux(cfg.route_upper, adc_iq_i, dac_iq_i, adc_cnt_q, glbl_cnt_q);
      wr_data_o.lower = route_mux(cfg.route_lower, adc_iq_i, dac_iq_i, adc_cnt_q, glbl_cnt_q);
    end
  end

endmodule

// ==== rtl/capture_pkg.sv ====
package capture_pkg;

  // one fifo word
  // upper half comes first on the stream
  typedef struct packed {
    logic [31:0] upper;
    logic [31:0] lower;
  } capture_word_t;

  // source of one capture half
  typedef enum logic [1:0] {
    route_adc_iq     = 2'b00,
    route_dac_iq     = 2'b01,
    route_adc_count  = 2'b10,
    route_glbl_count = 2'b11
  } route_sel_e;

  // apb register map, byte addresses
  localparam logic [7:0] reg_ctrl_addr         = 8'h00;
  localparam logic [7:0] reg_freq_offset_addr  = 8'h04;
  localparam logic [7:0] reg_tuning_coeff_addr = 8'h08;
  localparam logic [7:0] reg_count_max_addr    = 8'h0c;
  localparam logic [7:0] reg_status_addr       = 8'h10;

  // route field positions in the control register
  localparam int ctrl_route_lower_lsb = 0;
  localparam int ctrl_route_upper_lsb = 4;

endpackage

// ==== rtl/chirp_apb_regs.sv ====
`timescale 1ns/1ps

module chirp_apb_regs (
  input  logic        clk_245_76MHz,
  input  logic        cpu_reset,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [7:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  input  logic        status_ready_i,
  input  logic        status_active_i,
  input  logic        status_done_i,
  chirp_cfg_if.regs   cfg
);
  import chirp_dsp_pkg::*;
  import capture_pkg::*;

  logic [31:0]        ctrl_q;
  logic [phase_w-1:0] freq_offset_q;
  logic [phase_w-1:0] tuning_coeff_q;
  logic [phase_w-1:0] count_max_q;
  logic               access;
  logic               addr_ok;
  logic [31:0]        rd_mux;

  // access phase, single cycle since pready is tied high
  assign access = psel_i & penable_i;

  // address decode and read mux
  always_comb begin
    addr_ok = 1'b1;
    rd_mux  = '0;
    case (paddr_i)
      reg_ctrl_addr:         rd_mux = ctrl_q;
      reg_freq_offset_addr:  rd_mux = freq_offset_q;
      reg_tuning_coeff_addr: rd_mux = tuning_coeff_q;
      reg_count_max_addr:    rd_mux = count_max_q;
      reg_status_addr: begin
        // read only, a write here is an error
        addr_ok = ~pwrite_i;
        rd_mux  = {29'd0, status_done_i, status_active_i, status_ready_i};
      end
      default:               addr_ok = 1'b0;
    endcase
  end

  assign pready_o  = 1'b1;
  assign pslverr_o = access & ~addr_ok;
  // unmapped or idle reads return zero
  assign prdata_o  = (access & ~pwrite_i & addr_ok) ? rd_mux : '0;

  // write lands on the edge closing the access phase
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      ctrl_q         <= '0;
      freq_offset_q  <= '0;
      tuning_coeff_q <= '0;
      count_max_q    <= '0;
    end else if (access && pwrite_i && addr_ok) begin
      case (paddr_i)
        reg_ctrl_addr:         ctrl_q         <= pwdata_i;
        reg_freq_offset_addr:  freq_offset_q  <= pwdata_i;
        reg_tuning_coeff_addr: tuning_coeff_q <= pwdata_i;
        reg_count_max_addr:    count_max_q    <= pwdata_i;
        default: ;
      endcase
    end
  end

  assign cfg.freq_offset  = freq_offset_q;
  assign cfg.tuning_coeff = tuning_coeff_q;
  assign cfg.count_max    = count_max_q;
  // route fields out of the control word
  assign cfg.route_lower  = route_sel_e'(ctrl_q[ctrl_route_lower_lsb +: 2]);
  assign cfg.route_upper  = route_sel_e'(ctrl_q[ctrl_route_upper_lsb +: 2]);

endmodule

// ==== rtl/chirp_capture_top.sv ====
`timescale 1ns/1ps

module chirp_capture_top #(
  parameter int dds_latency = 2,
  parameter int adc_delay   = 100,
  parameter int fifo_depth  = 512
) (
  input  logic                       clk_245_76MHz,
  input  logic                       cpu_reset,
  // apb slave
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [7:0]                 paddr_i,
  input  logic [31:0]                pwdata_i,
  output logic [31:0]                prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  // chirp control and status
  input  logic                       chirp_init_i,
  input  logic                       chirp_enable_i,
  input  logic                       adc_enable_i,
  output logic                       chirp_ready_o,
  output logic                       chirp_active_o,
  output logic                       chirp_done_o,
  // capture stream
  output capture_pkg::capture_word_t m_tdata_o,
  output logic                       m_tvalid_o,
  output logic                       m_tlast_o,
  input  logic                       m_tready_i,
  output logic                       capture_overflow_o
);
  import chirp_dsp_pkg::*;
  import capture_pkg::*;

  chirp_cfg_if cfg_if ();

  iq_sample_t    dac_sample;
  logic          dac_valid;
  iq_sample_t    dac_iq;
  iq_sample_t    adc_iq;
  logic          sample_valid;
  capture_word_t wr_data;
  logic          wr_last;
  logic          wr_en;

  chirp_apb_regs chirp_apb_regs_i (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .status_ready_i  (chirp_ready_o),
    .status_active_i (chirp_active_o),
    .status_done_i   (chirp_done_o),
    .cfg           (cfg_if.regs)
  );

  chirp_nco #(.dds_latency(dds_latency)) chirp_nco_i (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .chirp_init_i   (chirp_init_i),
    .chirp_enable_i (chirp_enable_i),
    .cfg            (cfg_if.nco),
    .dac_sample_o   (dac_sample),
    .dac_valid_o    (dac_valid),
    .chirp_ready_o  (chirp_ready_o),
    .chirp_active_o (chirp_active_o),
    .chirp_done_o   (chirp_done_o)
  );

  adc_loopback_model #(.adc_delay(adc_delay)) adc_loopback_model_i (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .dac_sample_i   (dac_sample),
    .dac_valid_i    (dac_valid),
    .dac_iq_o       (dac_iq),
    .adc_iq_o       (adc_iq),
    .sample_valid_o (sample_valid)
  );

  capture_framer #(.dds_latency(dds_latency)) capture_framer_i (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .adc_enable_i   (adc_enable_i),
    .dac_iq_i       (dac_iq),
    .adc_iq_i       (adc_iq),
    .sample_valid_i (sample_valid),
    .cfg            (cfg_if.framer),
    .wr_data_o      (wr_data),
    .wr_last_o      (wr_last),
    .wr_en_o        (wr_en)
  );

  capture_fifo #(.fifo_depth(fifo_depth)) capture_fifo_i (
    .clk_245_76MHz (clk_245_76MHz),
    .cpu_reset     (cpu_reset),
    .wr_data_i     (wr_data),
    .wr_last_i     (wr_last),
    .wr_en_i       (wr_en),
    .m_tdata_o     (m_tdata_o),
    .m_tvalid_o    (m_tvalid_o),
    .m_tlast_o     (m_tlast_o),
    .m_tready_i    (m_tready_i),
    .overflow_o    (capture_overflow_o)
  );

endmodule

// ==== rtl/chirp_cfg_if.sv ====
`timescale 1ns/1ps

interface chirp_cfg_if;
  import chirp_dsp_pkg::*;
  import capture_pkg::*;

  // chirp settings
  logic [phase_w-1:0] freq_offset;
  logic [phase_w-1:0] tuning_coeff;
  logic [phase_w-1:0] count_max;

  // capture routing
  route_sel_e route_lower;
  route_sel_e route_upper;

  modport regs (output freq_offset, tuning_coeff, count_max, route_lower, route_upper);
  modport nco (input freq_offset, tuning_coeff, count_max);
  modport framer (input route_lower, route_upper);

endinterface

// ==== rtl/chirp_dsp_pkg.sv ====
package chirp_dsp_pkg;

  // one I or Q sample as driven to the dac
  localparam int sample_w = 16;

  // phase accumulator, step and chirp coefficient share this width
  localparam int phase_w = 32;

  // offset from I to Q
  // a quarter turn of the 16 bit phase word
  localparam logic [sample_w-1:0] quarter_turn = 16'h4000;

  // packed I/Q pair with I in the upper half, as on the dac bus
  typedef struct packed {
    logic [sample_w-1:0] i;
    logic [sample_w-1:0] q;
  } iq_sample_t;

endpackage

// ==== rtl/chirp_nco.sv ====
`timescale 1ns/1ps

module chirp_nco #(
  parameter int dds_latency = 2
) (
  input  logic                      clk_245_76MHz,
  input  logic                      cpu_reset,
  input  logic                      chirp_init_i,
  input  logic                      chirp_enable_i,
  chirp_cfg_if.nco                  cfg,
  output chirp_dsp_pkg::iq_sample_t dac_sample_o,
  output logic                      dac_valid_o,
  output logic                      chirp_ready_o,
  output logic                      chirp_active_o,
  output logic                      chirp_done_o
);
  import chirp_dsp_pkg::*;

  logic [phase_w-1:0]     phase_q;
  logic [phase_w-1:0]     step_q;
  logic [phase_w-1:0]     count_q;
  logic [phase_w-1:0]     phase_next;
  logic                   run;
  logic                   ready_q;
  logic                   done_q;
  logic                   valid_q;
  iq_sample_t             sample_next;
  iq_sample_t             pipe_q [dds_latency];
  logic [dds_latency-1:0] act_pipe_q;
  logic [dds_latency-1:0] last_pipe_q;

  // one chirp step per enabled cycle until count_max
  assign run = ready_q & chirp_enable_i & (count_q < cfg.count_max);

  // step_q holds only the accumulated coefficient, offset added on top
  assign phase_next    = phase_q + cfg.freq_offset + step_q;
  // I from the top phase bits, Q a quarter turn ahead
  assign sample_next.i = phase_next[phase_w-1 -: sample_w];
  assign sample_next.q = phase_next[phase_w-1 -: sample_w] + quarter_turn;

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset || chirp_init_i) begin
      phase_q <= '0;
      step_q  <= '0;
      count_q <= '0;
    end else if (run) begin
      phase_q <= phase_next;
      step_q  <= step_q + cfg.tuning_coeff;
      count_q <= count_q + 1'b1;
    end
  end

  // sample pipeline, zero when idle
  always_ff @(posedge clk_245_76MHz) begin
    pipe_q[0] <= run ? sample_next : '0;
    for (int s = 1; s < dds_latency; s++) begin
      pipe_q[s] <= pipe_q[s-1];
    end
  end

  // status flags travel alongside the samples
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      act_pipe_q  <= '0;
      last_pipe_q <= '0;
    end else begin
      act_pipe_q[0]  <= run;
      last_pipe_q[0] <= run & (count_q == cfg.count_max - 1'b1);
      for (int s = 1; s < dds_latency; s++) begin
        act_pipe_q[s]  <= act_pipe_q[s-1];
        last_pipe_q[s] <= last_pipe_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      ready_q <= 1'b0;
      done_q  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      // adc side samples every cycle
      valid_q <= 1'b1;
      if (chirp_init_i) begin
        ready_q <= 1'b1;
        done_q  <= 1'b0;
      end else if (last_pipe_q[dds_latency-1]) begin
        // last sample has left the output stage
        ready_q <= 1'b0;
        done_q  <= 1'b1;
      end
    end
  end

  assign dac_sample_o   = pipe_q[dds_latency-1];
  assign dac_valid_o    = valid_q;
  assign chirp_ready_o  = ready_q;
  assign chirp_active_o = act_pipe_q[dds_latency-1];
  assign chirp_done_o   = done_q;

endmodule

// ==== sim.f ====
rtl/chirp_dsp_pkg.sv
rtl/capture_pkg.sv
rtl/chirp_cfg_if.sv
rtl/chirp_apb_regs.sv
rtl/chirp_nco.sv
rtl/adc_loopback_model.sv
rtl/capture_framer.sv
rtl/capture_fifo.sv
rtl/chirp_capture_top.sv
verification/chirp_capture_tb.sv

// ==== verification/chirp_capture_tb.sv ====
`timescale 1ns/1ps

module chirp_capture_tb;
  import chirp_dsp_pkg::*;
  import capture_pkg::*;

  localparam int clk_period = 100;
  localparam int adc_delay  = 8;
  localparam int fifo_depth = 64;
  localparam int max_count  = 30;
  // cycle budget of each test
  // the watchdog waits for their sum plus a margin
  localparam int apb_cycles       = 150;
  localparam int chirp_cycles     = 2 * (max_count + adc_delay + 80);
  localparam int marker_cycles    = 150;
  localparam int backpress_cycles = 6 * fifo_depth + 200;
  localparam int watchdog_cycles  = apb_cycles + chirp_cycles + marker_cycles +
                                    backpress_cycles + 2000;

  logic          clk_245_76MHz;
  logic          cpu_reset;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [7:0]    paddr;
  logic [31:0]   pwdata;
  logic [31:0]   prdata;
  logic          pready;
  logic          pslverr;
  logic          chirp_init;
  logic          chirp_enable;
  logic          adc_enable;
  logic          chirp_ready;
  logic          chirp_active;
  logic          chirp_done;
  capture_word_t m_tdata;
  logic          m_tvalid;
  logic          m_tlast;
  logic          m_tready;
  logic          capture_overflow;

  // received stream and the end index of each frame
  capture_word_t rx_words [$];
  int            frame_ends [$];
  int            frames_checked = 0;
  int            frames_started = 0;
  int            data_total = 0;
  int            cur_test = 0;
  string         test_name = "reset";
  logic [31:0]   chirp_offset;
  logic [31:0]   chirp_coeff;
  logic [31:0]   chirp_count;
  logic          ready_random;
  logic          ready_hold;

  chirp_capture_top #(
    .adc_delay  (adc_delay),
    .fifo_depth (fifo_depth)
  ) chirp_capture_top_i (
    .clk_245_76MHz      (clk_245_76MHz),
    .cpu_reset          (cpu_reset),
    .psel_i             (psel),
    .penable_i          (penable),
    .pwrite_i           (pwrite),
    .paddr_i            (paddr),
    .pwdata_i           (pwdata),
    .prdata_o           (prdata),
    .pready_o           (pready),
    .pslverr_o          (pslverr),
    .chirp_init_i       (chirp_init),
    .chirp_enable_i     (chirp_enable),
    .adc_enable_i       (adc_enable),
    .chirp_ready_o      (chirp_ready),
    .chirp_active_o     (chirp_active),
    .chirp_done_o       (chirp_done),
    .m_tdata_o          (m_tdata),
    .m_tvalid_o         (m_tvalid),
    .m_tlast_o          (m_tlast),
    .m_tready_i         (m_tready),
    .capture_overflow_o (capture_overflow)
  );

  initial begin
    clk_245_76MHz = 1'b0;
    forever #(clk_period / 2) clk_245_76MHz = ~clk_245_76MHz;
  end

  task automatic fail_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    $display("FAILED %s %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    $display("TEST FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic fail_text(input string what);
    $display("%s: %s", test_name, what);
    $display("TEST FAILED");
    $fatal(1, "check failed");
  endtask

  // expected I of chirp sample n
  // the first step equals the offset
  function automatic logic [15:0] ref_chirp_i(input logic [31:0] offset,
                                              input logic [31:0] coeff, input int n);
    logic [31:0] phase;
    logic [31:0] step;
    phase = '0;
    step  = offset;
    for (int k = 0; k <= n; k++) begin
      phase = phase + step;
      step  = step + coeff;
    end
    return phase[31:16];
  endfunction

  // half of a signed sample rounded toward minus infinity
  function automatic logic [15:0] ref_half(input logic [15:0] x);
    int v;
    v = int'($signed(x));
    if (v < 0 && (v % 2) != 0) begin
      v = v - 1;
    end
    return 16'(v / 2);
  endfunction

  // setup phase then access phase
  // pready stays high so the access lasts one cycle
  task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(posedge clk_245_76MHz);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk_245_76MHz);
    penable <= 1'b1;
    @(posedge clk_245_76MHz);
    rdata = prdata;
    err   = pslverr;
    assert (pready == 1'b1) else fail_text("pready was low in the access phase");
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b1, data, rdata, err);
    assert (err == 1'b0) else fail_value("pslverr on write", 0, err);
  endtask

  task automatic reg_read_check(input string what, input logic [7:0] addr,
                                input logic [31:0] exp, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(addr, 1'b0, '0, rdata, err);
    assert (err == exp_err) else fail_value({what, " pslverr"}, exp_err, err);
    assert (rdata == exp) else fail_value(what, exp, rdata);
  endtask

  task automatic wait_frames(input int target);
    while (frames_checked != target) @(posedge clk_245_76MHz);
  endtask

  // one chirp inside one capture frame
  task automatic capture_chirp(input logic [31:0] ctrl);
    int active_cycles;
    int frames_before;
    frames_before = frames_checked;
    frames_started++;
    chirp_offset  = $urandom_range(1, 65535) * 32'd65536;
    chirp_coeff   = $urandom_range(0, 65535) * 32'd65536;
    chirp_count   = $urandom_range(16, max_count);
    reg_write(reg_freq_offset_addr, chirp_offset);
    reg_write(reg_tuning_coeff_addr, chirp_coeff);
    reg_write(reg_count_max_addr, chirp_count);
    reg_write(reg_ctrl_addr, ctrl);
    @(posedge clk_245_76MHz);
    adc_enable <= 1'b1;
    repeat (4) @(posedge clk_245_76MHz);
    chirp_init <= 1'b1;
    @(posedge clk_245_76MHz);
    chirp_init   <= 1'b0;
    chirp_enable <= 1'b1;
    active_cycles = 0;
    do begin
      @(posedge clk_245_76MHz);
      if (chirp_active) active_cycles++;
    end while (!chirp_done);
    chirp_enable <= 1'b0;
    assert (active_cycles == chirp_count)
      else fail_value("active cycles", chirp_count, active_cycles);
    // only done is left set
    reg_read_check("status after chirp", reg_status_addr, 32'h4, 1'b0);
    // let the tail pass the adc delay line
    repeat (adc_delay + 8) @(posedge clk_245_76MHz);
    adc_enable <= 1'b0;
    wait_frames(frames_before + 1);
  endtask

  task automatic capture_plain(input int cycles);
    int frames_before;
    frames_before = frames_checked;
    frames_started++;
    @(posedge clk_245_76MHz);
    adc_enable <= 1'b1;
    repeat (cycles) @(posedge clk_245_76MHz);
    adc_enable <= 1'b0;
    wait_frames(frames_before + 1);
  endtask

  // stream sink ready
  always @(posedge clk_245_76MHz) begin
    if (ready_random) begin
      m_tready <= 1'($urandom_range(0, 1));
    end else begin
      m_tready <= ready_hold;
    end
  end

  // collector takes a word on valid and ready
  always @(posedge clk_245_76MHz) begin
    if (!cpu_reset && m_tvalid && m_tready) begin
      rx_words.push_back(m_tdata);
      if (m_tlast) frame_ends.push_back(rx_words.size());
    end
  end

  // compares one finished frame at a time
  initial begin
    int            first;
    int            last;
    int            n_data;
    int            j;
    capture_word_t head;
    capture_word_t tail;
    capture_word_t w;
    capture_word_t prev;
    logic [15:0]   diff;
    logic [31:0]   exp_word;
    forever begin
      @(negedge clk_245_76MHz);
      if (frame_ends.size() > frames_checked) begin
        first  = (frames_checked == 0) ? 0 : frame_ends[frames_checked - 1];
        last   = frame_ends[frames_checked] - 1;
        n_data = last - first - 1;
        head   = rx_words[first];
        tail   = rx_words[last];
        assert (n_data >= 0) else fail_text("frame holds fewer than two marker words");
        // marker relations
        assert (head.lower == data_total) else fail_value("first marker count", data_total,
                                                         head.lower);
        assert (tail.lower - head.lower == n_data)
          else fail_value("marker count span", n_data, tail.lower - head.lower);
        assert (tail.upper - head.upper >= n_data)
          else fail_value("marker global span", n_data, tail.upper - head.upper);
        if (cur_test == 2) begin
          j = first + 1;
          while (j < last && rx_words[j] == '0) j++;
          assert (j + chirp_count <= last) else fail_text("chirp samples missing from frame");
          for (int k = 0; k < chirp_count; k++) begin
            w    = rx_words[j + k];
            diff = w.lower[15:0] - w.lower[31:16];
            assert (w.lower[31:16] == ref_chirp_i(chirp_offset, chirp_coeff, k))
              else fail_value("chirp I", ref_chirp_i(chirp_offset, chirp_coeff, k),
                              w.lower[31:16]);
            assert (diff == quarter_turn) else fail_value("Q minus I", quarter_turn, diff);
            assert (w.upper == w.lower) else fail_value("upper dac half", w.lower, w.upper);
          end
        end else if (cur_test == 3) begin
          for (int k = adc_delay; k < n_data; k++) begin
            w        = rx_words[first + 1 + k];
            prev     = rx_words[first + 1 + k - adc_delay];
            exp_word = {ref_half(prev.lower[31:16]), ref_half(prev.lower[15:0])};
            assert (w.upper == exp_word) else fail_value("adc sample", exp_word, w.upper);
          end
        end else if (cur_test == 5) begin
          // adc count in the lower half and global count in the upper
          for (int k = 0; k < n_data; k++) begin
            w = rx_words[first + 1 + k];
            assert (w.lower == head.lower + k)
              else fail_value("adc count word", head.lower + k, w.lower);
            assert (w.upper == head.upper + 1 + k)
              else fail_value("global count word", head.upper + 1 + k, w.upper);
          end
        end
        data_total = data_total + n_data;
        frames_checked++;
      end
    end
  end

  // watchdog
  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout, the run went past %0d cycles without finishing", watchdog_cycles);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [31:0] val;
    int          pending_start;
    void'($urandom(97));
    cpu_reset    = 1'b1;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    chirp_init   = 1'b0;
    chirp_enable = 1'b0;
    adc_enable   = 1'b0;
    m_tready     = 1'b0;
    ready_random = 1'b0;
    ready_hold   = 1'b1;
    repeat (4) @(posedge clk_245_76MHz);
    cpu_reset <= 1'b0;
    @(posedge clk_245_76MHz);
    assert (m_tvalid == 1'b0) else fail_value("m_tvalid after reset", 0, m_tvalid);
    assert (m_tlast == 1'b0) else fail_value("m_tlast after reset", 0, m_tlast);
    assert (chirp_ready == 1'b0) else fail_value("ready after reset", 0, chirp_ready);
    assert (chirp_active == 1'b0) else fail_value("active after reset", 0, chirp_active);
    assert (chirp_done == 1'b0) else fail_value("done after reset", 0, chirp_done);
    assert (capture_overflow == 1'b0) else fail_value("overflow after reset", 0,
                                                     capture_overflow);
    assert (pslverr == 1'b0) else fail_value("pslverr after reset", 0, pslverr);

    test_name = "apb_registers";
    reg_read_check("status after reset", reg_status_addr, '0, 1'b0);
    val = $urandom();
    reg_write(reg_freq_offset_addr, val);
    reg_read_check("freq offset", reg_freq_offset_addr, val, 1'b0);
    val = $urandom();
    reg_write(reg_tuning_coeff_addr, val);
    reg_read_check("tuning coeff", reg_tuning_coeff_addr, val, 1'b0);
    val = $urandom();
    reg_write(reg_count_max_addr, val);
    reg_read_check("count max", reg_count_max_addr, val, 1'b0);
    val = $urandom();
    reg_write(reg_ctrl_addr, val);
    reg_read_check("ctrl", reg_ctrl_addr, val, 1'b0);
    // unmapped address gives an error and ignores the write
    apb_access(8'h40, 1'b1, val, rdata, err);
    assert (err == 1'b1) else fail_value("unmapped write pslverr", 1, err);
    reg_read_check("unmapped read", 8'h40, '0, 1'b1);

    test_name = "chirp_sequence";
    cur_test  = 2;
    capture_chirp(32'h11);

    test_name = "loopback";
    cur_test  = 3;
    capture_chirp(32'h01);

    test_name = "frame_markers";
    cur_test  = 4;
    capture_plain($urandom_range(1, 40));
    capture_plain($urandom_range(1, 40));

    test_name = "backpressure";
    cur_test  = 5;
    reg_write(reg_ctrl_addr, 32'h32);
    ready_random <= 1'b1;
    capture_plain($urandom_range(20, 40));
    assert (capture_overflow == 1'b0) else fail_value("overflow before full", 0,
                                                     capture_overflow);
    // stalled sink and a frame longer than the fifo
    ready_random <= 1'b0;
    ready_hold   <= 1'b0;
    pending_start = rx_words.size();
    @(posedge clk_245_76MHz);
    adc_enable <= 1'b1;
    repeat (fifo_depth + 20) @(posedge clk_245_76MHz);
    adc_enable <= 1'b0;
    repeat (10) @(posedge clk_245_76MHz);
    assert (capture_overflow == 1'b1) else fail_value("overflow flag", 1, capture_overflow);
    ready_hold <= 1'b1;
    repeat (2) @(posedge clk_245_76MHz);
    do begin
      @(posedge clk_245_76MHz);
    end while (m_tvalid);
    assert (rx_words.size() - pending_start == fifo_depth)
      else fail_value("words drained after overflow", fifo_depth,
                      rx_words.size() - pending_start);
    // one closing m_tlast per finished capture and none in the dropped frame
    assert (frame_ends.size() == frames_started)
      else fail_value("closed frames", frames_started, frame_ends.size());

    $display("TEST PASSED");
    $finish;
  end

endmodule
